//--- fp_unit.f
+incdir+tests
source/fp_format_pkg.sv
source/fp_ctrl_pkg.sv
source/fp_op_if.sv
source/fp_add.sv
source/fp_mul.sv
source/fp_convert.sv
source/fp_exec.sv
source/fp_apb_regs.sv
source/fp_unit_top.sv
tests/fp_unit_tb.sv

//--- Bender.yml
package:
  name: fp_unit

sources:
  - source/fp_format_pkg.sv
  - source/fp_ctrl_pkg.sv
  - source/fp_op_if.sv
  - source/fp_add.sv
  - source/fp_mul.sv
  - source/fp_convert.sv
  - source/fp_exec.sv
  - source/fp_apb_regs.sv
  - source/fp_unit_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/fp_unit_tb.sv

//--- tests/fp_unit_ref.svh
`ifndef FP_UNIT_REF_SVH
`define FP_UNIT_REF_SVH

// ========================================
// Random numbers
// ========================================

// LCG state with a fixed seed
int unsigned rng_state = 67;

// Next raw value with the weak low bits dropped
function automatic int unsigned next_random();
	rng_state = rng_state * 32'd1664525 + 32'd1013904223;
	return rng_state >> 8;
endfunction

// Uniform value in lo..hi inclusive
function automatic int random_in(input int lo, input int hi);
	int unsigned span;
	span = unsigned'(hi - lo + 1);
	return lo + int'(next_random() % span);
endfunction

// ========================================
// Expected float words
// ========================================

// Sign, biased exponent and stored fraction into one word
function automatic fp_format_pkg::fp_word_t pack_word(input logic sign, input int exp,
	input int frac);
	return {sign, exp[7:0], frac[17:0]};
endfunction

// Exact encoding of a 16-bit integer
function automatic fp_format_pkg::fp_word_t int_to_word(input int v);
	int mag;
	int pos;
	mag = (v < 0) ? -v : v;
	if (mag == 0)
		return '0;
	// Position of the leading one
	pos = 0;
	while ((mag >> (pos + 1)) != 0)
		pos++;
	// Leading one hidden and the remaining bits at the top of the fraction
	return pack_word(v < 0, int'(fp_format_pkg::FP_BIAS) + pos,
		(mag << (fp_format_pkg::FP_FRAC_W - pos)) & 32'h3FFFF);
endfunction

`endif

//--- tests/fp_unit_tb.sv
module fp_unit_tb;

	localparam int CLK_PERIOD = 40;
	localparam int ADDR_W = 8;

	// Test sizes
	localparam int N_ROUND = 20;
	localparam int N_ARITH = 8;
	localparam int N_CMP = 12;
	localparam int N_RANGE = 6;

	// One operation is three writes, two STATUS polls and one read
	localparam int OP_ACCESSES = 6;
	localparam int N_OPS = 1 + 2 * N_ROUND + 8 * N_ARITH + 3 * N_CMP + 2 + N_RANGE;
	localparam int PLANNED_ACCESSES = N_OPS * OP_ACCESSES + 30;
	localparam int WATCHDOG_TIME = PLANNED_ACCESSES * 10 * CLK_PERIOD;

	logic iCLK;
	logic reset_key;
	logic [ADDR_W-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	fp_ctrl_pkg::apb_data_t pwdata;
	fp_ctrl_pkg::apb_data_t prdata;
	logic pready;
	logic pslverr;

	// Values seen in the last access phase
	fp_ctrl_pkg::apb_data_t rd_data;
	logic rd_err;
	logic rd_ready;

	int checks = 0;
	int errors = 0;

	`include "fp_unit_ref.svh"

	fp_unit_top #(
		.APB_ADDR_W(ADDR_W)
	) UUT (
		.iCLK(iCLK),
		.reset_key(reset_key),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	always #(CLK_PERIOD / 2) iCLK = ~iCLK;

	// ========================================
	// APB master
	// ========================================

	// Entered and left on a falling edge
	task automatic apb_access(input logic [ADDR_W-1:0] addr, input logic wr,
		input fp_ctrl_pkg::apb_data_t data);
		// Setup phase
		paddr = addr;
		pwrite = wr;
		pwdata = data;
		psel = 1'b1;
		penable = 1'b0;
		@(negedge iCLK);
		// Access phase, sampled a quarter period before the rising edge
		penable = 1'b1;
		#(CLK_PERIOD / 4);
		rd_data = prdata;
		rd_err = pslverr;
		rd_ready = pready;
		@(negedge iCLK);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic check_value(input string name, input fp_ctrl_pkg::apb_data_t got,
		input fp_ctrl_pkg::apb_data_t exp);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// Write with the expected error response
	task automatic write_reg(input logic [ADDR_W-1:0] addr, input fp_ctrl_pkg::apb_data_t data,
		input logic exp_err);
		apb_access(addr, 1'b1, data);
		check_value("pslverr", rd_err, exp_err);
	endtask

	task automatic read_reg(input logic [ADDR_W-1:0] addr, output fp_ctrl_pkg::apb_data_t data);
		apb_access(addr, 1'b0, '0);
		data = rd_data;
	endtask

	// Poll STATUS until the busy flag drops
	task automatic wait_idle();
		int polls;
		polls = 0;
		do begin
			apb_access(fp_ctrl_pkg::REG_STATUS, 1'b0, '0);
			polls++;
		end while ((rd_data != 0) && (polls < 8));
		assert (rd_data == 0)
		else begin
			errors++;
			$display("Command still busy after %0d STATUS polls at %0t", polls, $time);
		end
	endtask

	// ========================================
	// Operations
	// ========================================

	task automatic run_op(input fp_ctrl_pkg::fp_op_e op, input fp_ctrl_pkg::apb_data_t a,
		input fp_ctrl_pkg::apb_data_t b, output fp_ctrl_pkg::apb_data_t res);
		write_reg(fp_ctrl_pkg::REG_A, a, 1'b0);
		write_reg(fp_ctrl_pkg::REG_B, b, 1'b0);
		write_reg(fp_ctrl_pkg::REG_CMD, fp_ctrl_pkg::apb_data_t'(op), 1'b0);
		wait_idle();
		read_reg(fp_ctrl_pkg::REG_RESULT, res);
	endtask

	// Integer sits in the low half of A
	task automatic int_to_float(input int v, output fp_format_pkg::fp_word_t w);
		fp_ctrl_pkg::apb_data_t res;
		run_op(fp_ctrl_pkg::OP_I2F, {16'h0000, v[15:0]}, '0, res);
		check_value("RESULT", res, fp_ctrl_pkg::apb_data_t'(int_to_word(v)));
		w = res[26:0];
	endtask

	task automatic float_to_int(input fp_format_pkg::fp_word_t w,
		output fp_ctrl_pkg::apb_data_t res);
		run_op(fp_ctrl_pkg::OP_F2I, fp_ctrl_pkg::apb_data_t'(w), '0, res);
	endtask

	// Convert both, operate, convert back
	task automatic arith_case(input fp_ctrl_pkg::fp_op_e op, input int x, input int y,
		input int expected);
		fp_format_pkg::fp_word_t wa;
		fp_format_pkg::fp_word_t wb;
		fp_ctrl_pkg::apb_data_t res;
		fp_ctrl_pkg::apb_data_t back;
		int_to_float(x, wa);
		int_to_float(y, wb);
		run_op(op, fp_ctrl_pkg::apb_data_t'(wa), fp_ctrl_pkg::apb_data_t'(wb), res);
		float_to_int(res[26:0], back);
		check_value("RESULT", back, fp_ctrl_pkg::apb_data_t'(expected));
	endtask

	task automatic compare_case(input int x, input int y);
		fp_format_pkg::fp_word_t wa;
		fp_format_pkg::fp_word_t wb;
		fp_ctrl_pkg::apb_data_t res;
		int_to_float(x, wa);
		int_to_float(y, wb);
		run_op(fp_ctrl_pkg::OP_CMP, fp_ctrl_pkg::apb_data_t'(wa),
			fp_ctrl_pkg::apb_data_t'(wb), res);
		check_value("RESULT", res, (x >= y) ? 32'd1 : 32'd0);
	endtask

	// ========================================
	// Stimulus
	// ========================================

	initial begin
		int x;
		int y;
		int i;
		int e;
		int s;
		fp_format_pkg::fp_word_t w;
		fp_ctrl_pkg::apb_data_t res;
		fp_ctrl_pkg::apb_data_t r0;
		iCLK = 1'b0;
		reset_key = 1'b1;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		repeat (2) @(posedge iCLK);
		@(negedge iCLK);
		reset_key = 1'b0;

		// Reset state
		read_reg(fp_ctrl_pkg::REG_STATUS, res);
		check_value("STATUS", res, '0);
		check_value("pready", rd_ready, 1'b1);
		read_reg(fp_ctrl_pkg::REG_RESULT, res);
		check_value("RESULT", res, '0);
		read_reg(fp_ctrl_pkg::REG_A, res);
		check_value("A", res, '0);
		read_reg(fp_ctrl_pkg::REG_B, res);
		check_value("B", res, '0);

		// Integer round trip, 1.0 first
		int_to_float(1, w);
		check_value("RESULT", w, 32'h01FC0000);
		for (i = 0; i < N_ROUND; i++) begin
			x = random_in(-32767, 32767);
			int_to_float(x, w);
			float_to_int(w, res);
			check_value("RESULT", res, fp_ctrl_pkg::apb_data_t'(x));
		end

		// Add and multiply, first pass with a zero operand
		for (i = 0; i < N_ARITH; i++) begin
			x = (i == 0) ? 0 : random_in(-1000, 1000);
			y = random_in(-1000, 1000);
			arith_case(fp_ctrl_pkg::OP_ADD, x, y, x + y);
			x = random_in(-100, 100);
			y = (i == 0) ? 0 : random_in(-100, 100);
			arith_case(fp_ctrl_pkg::OP_MUL, x, y, x * y);
		end

		// Compare: equal, opposite signs, free pairs
		for (i = 0; i < N_CMP; i++) begin
			x = random_in(-1000, 1000);
			case (i % 3)
				0: y = x;
				1: y = -x;
				default: y = random_in(-1000, 1000);
			endcase
			compare_case(x, y);
		end

		// Saturation at exponent 150
		float_to_int(pack_word(1'b0, 150, random_in(0, 32'h3FFFF)), res);
		check_value("RESULT", res, fp_ctrl_pkg::apb_data_t'(32767));
		float_to_int(pack_word(1'b1, 150, random_in(0, 32'h3FFFF)), res);
		check_value("RESULT", res, fp_ctrl_pkg::apb_data_t'(-32767));
		// Magnitude below one
		for (i = 0; i < N_RANGE; i++) begin
			e = random_in(0, 126);
			s = random_in(0, 1);
			float_to_int(pack_word(s[0], e, random_in(0, 32'h3FFFF)), res);
			check_value("RESULT", res, '0);
		end

		// Error responses leave RESULT and busy alone
		read_reg(fp_ctrl_pkg::REG_RESULT, r0);
		apb_access(8'h20, 1'b0, '0);
		check_value("pslverr", rd_err, 1'b1);
		write_reg(8'h24, 32'h00001234, 1'b1);
		write_reg(fp_ctrl_pkg::REG_RESULT, 32'hDEADBEEF, 1'b1);
		write_reg(fp_ctrl_pkg::REG_CMD, 32'd6, 1'b1);
		read_reg(fp_ctrl_pkg::REG_STATUS, res);
		check_value("STATUS", res, '0);
		read_reg(fp_ctrl_pkg::REG_RESULT, res);
		check_value("RESULT", res, r0);

		// Second CMD lands inside the add latency
		write_reg(fp_ctrl_pkg::REG_A, fp_ctrl_pkg::apb_data_t'(int_to_word(3)), 1'b0);
		write_reg(fp_ctrl_pkg::REG_B, fp_ctrl_pkg::apb_data_t'(int_to_word(4)), 1'b0);
		write_reg(fp_ctrl_pkg::REG_CMD, fp_ctrl_pkg::apb_data_t'(fp_ctrl_pkg::OP_ADD), 1'b0);
		write_reg(fp_ctrl_pkg::REG_CMD, fp_ctrl_pkg::apb_data_t'(fp_ctrl_pkg::OP_MUL), 1'b1);
		wait_idle();
		read_reg(fp_ctrl_pkg::REG_RESULT, res);
		check_value("RESULT", res, fp_ctrl_pkg::apb_data_t'(int_to_word(7)));

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_TIME);
		$display("Run did not finish in time after %0d checks, errors: %0d", checks, errors);
		$display("Something failed");
		$finish;
	end

endmodule

//--- source/fp_unit_top.sv
module fp_unit_top #(
	parameter int APB_ADDR_W = 8
) (
	input logic iCLK,
	input logic reset_key,
	input logic [APB_ADDR_W-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input fp_ctrl_pkg::apb_data_t pwdata,
	output fp_ctrl_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr
);

	// Operation channel between registers and sequencer
	fp_op_if op_bus ();

	fp_apb_regs #(
		.APB_ADDR_W(APB_ADDR_W)
	) u_regs (
		.iCLK(iCLK),
		.reset_key(reset_key),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.op_bus(op_bus.regs)
	);

	fp_exec u_exec (.iCLK(iCLK), .reset_key(reset_key), .op_bus(op_bus.exec));

endmodule

//--- source/fp_apb_regs.sv
module fp_apb_regs #(
	parameter int APB_ADDR_W = 8
) (
	input logic iCLK,
	input logic reset_key,
	input logic [APB_ADDR_W-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input fp_ctrl_pkg::apb_data_t pwdata,
	output fp_ctrl_pkg::apb_data_t prdata,
	output logic pready,
	output logic pslverr,
	fp_op_if.regs op_bus
);

	typedef logic [APB_ADDR_W-1:0] apb_addr_t;

	// Register state
	fp_format_pkg::fp_word_t reg_a;
	fp_format_pkg::fp_word_t reg_b;
	fp_ctrl_pkg::fp_op_e reg_op;
	fp_ctrl_pkg::apb_data_t reg_result;
	logic busy;
	logic start_q;

	// Decode
	logic access;
	logic sel_a;
	logic sel_b;
	logic sel_cmd;
	logic sel_status;
	logic sel_result;
	logic mapped;
	logic code_ok;
	logic cmd_ok;

	// ========================================
	// Address decode and error check
	// ========================================

	assign access = psel && penable;
	assign sel_a = (paddr == apb_addr_t'(fp_ctrl_pkg::REG_A));
	assign sel_b = (paddr == apb_addr_t'(fp_ctrl_pkg::REG_B));
	assign sel_cmd = (paddr == apb_addr_t'(fp_ctrl_pkg::REG_CMD));
	assign sel_status = (paddr == apb_addr_t'(fp_ctrl_pkg::REG_STATUS));
	assign sel_result = (paddr == apb_addr_t'(fp_ctrl_pkg::REG_RESULT));
	assign mapped = sel_a || sel_b || sel_cmd || sel_status || sel_result;

	// Only codes up to compare, upper bits clear
	assign code_ok = (pwdata[31:3] == '0) && (pwdata[2:0] <= 3'(fp_ctrl_pkg::OP_CMP));

	// Command accepted only when idle
	assign cmd_ok = access && pwrite && sel_cmd && code_ok && !busy;

	// Zero wait states
	assign pready = 1'b1;

	assign pslverr = access && (!mapped
		|| (pwrite && (sel_status || sel_result))
		|| (pwrite && sel_cmd && !cmd_ok));

	// ========================================
	// Registers
	// ========================================

	always_ff @(posedge iCLK) begin
		if (reset_key) begin
			reg_a <= '0;
			reg_b <= '0;
			reg_op <= fp_ctrl_pkg::OP_ADD;
			reg_result <= '0;
			busy <= 1'b0;
			start_q <= 1'b0;
		end else begin
			// Operand writes
			if (access && pwrite && sel_a)
				reg_a <= pwdata[26:0];
			if (access && pwrite && sel_b)
				reg_b <= pwdata[26:0];

			// Start pulse the cycle after the CMD access
			start_q <= cmd_ok;
			if (cmd_ok) begin
				reg_op <= fp_ctrl_pkg::fp_op_e'(pwdata[2:0]);
				busy <= 1'b1;
			end

			// Completion from the sequencer
			if (op_bus.done) begin
				reg_result <= op_bus.result;
				busy <= 1'b0;
			end
		end
	end

	// Read mux
	always_comb begin
		prdata = '0;
		if (sel_a)
			prdata = fp_ctrl_pkg::apb_data_t'(reg_a);
		else if (sel_b)
			prdata = fp_ctrl_pkg::apb_data_t'(reg_b);
		else if (sel_cmd)
			prdata = fp_ctrl_pkg::apb_data_t'(reg_op);
		else if (sel_status)
			prdata = fp_ctrl_pkg::apb_data_t'(busy);
		else if (sel_result)
			prdata = reg_result;
	end

	// Towards the sequencer
	assign op_bus.a = reg_a;
	assign op_bus.b = reg_b;
	assign op_bus.op = reg_op;
	assign op_bus.start = start_q;

endmodule

//--- source/fp_exec.sv
module fp_exec (
	input logic iCLK,
	input logic reset_key,
	fp_op_if.exec op_bus
);

	// Sequencer state
	fp_ctrl_pkg::fp_op_e op_q;
	logic add_pend;
	logic done_q;
	fp_ctrl_pkg::apb_data_t res_q;

	// Unit outputs
	fp_format_pkg::fp_word_t sum;
	fp_format_pkg::fp_word_t prod;
	fp_format_pkg::fp_word_t i2f_word;
	fp_format_pkg::int16_t f2i_int;

	// Compare fields
	logic a_sign;
	logic b_sign;
	fp_format_pkg::fp_exp_t a_exp;
	fp_format_pkg::fp_exp_t b_exp;
	fp_format_pkg::fp_frac_t a_frac;
	fp_format_pkg::fp_frac_t b_frac;
	logic mag_gt;
	logic mag_eq;
	logic a_ge_b;

	// ========================================
	// Arithmetic units
	// ========================================

	fp_add u_add (.iCLK(iCLK), .a(op_bus.a), .b(op_bus.b), .sum(sum));

	fp_mul u_mul (.a(op_bus.a), .b(op_bus.b), .prod(prod));

	// Integer source sits in the low half of A
	fp_convert u_convert (
		.a(op_bus.a),
		.int_in(fp_format_pkg::int16_t'(op_bus.a[15:0])),
		.fp_out(i2f_word),
		.int_out(f2i_int)
	);

	// ========================================
	// Compare, A >= B
	// ========================================

	assign a_sign = op_bus.a[fp_format_pkg::FP_SIGN_POS];
	assign b_sign = op_bus.b[fp_format_pkg::FP_SIGN_POS];
	assign a_exp = op_bus.a[fp_format_pkg::FP_EXP_MSB:fp_format_pkg::FP_EXP_LSB];
	assign b_exp = op_bus.b[fp_format_pkg::FP_EXP_MSB:fp_format_pkg::FP_EXP_LSB];
	assign a_frac = op_bus.a[fp_format_pkg::FP_FRAC_W-1:0];
	assign b_frac = op_bus.b[fp_format_pkg::FP_FRAC_W-1:0];

	// Magnitude order, exponent first
	assign mag_gt = (a_exp > b_exp) || ((a_exp == b_exp) && (a_frac > b_frac));
	assign mag_eq = (a_exp == b_exp) && (a_frac == b_frac);

	always_comb begin
		case ({a_sign, b_sign})
			2'b01: a_ge_b = 1'b1;
			2'b10: a_ge_b = 1'b0;
			2'b00: a_ge_b = mag_gt || mag_eq;
			// Both negative, larger magnitude is smaller
			default: a_ge_b = !mag_gt;
		endcase
	end

	// ========================================
	// Sequencing
	// ========================================

	always_ff @(posedge iCLK) begin
		if (reset_key) begin
			op_q <= fp_ctrl_pkg::OP_ADD;
			add_pend <= 1'b0;
			done_q <= 1'b0;
		end else begin
			if (op_bus.start)
				op_q <= op_bus.op;
			// Adder needs one more stage
			add_pend <= op_bus.start && (op_bus.op == fp_ctrl_pkg::OP_ADD);
			done_q <= (op_bus.start && (op_bus.op != fp_ctrl_pkg::OP_ADD)) || add_pend;
		end
	end

	// Single-cycle results
	always_ff @(posedge iCLK) begin
		if (op_bus.start) begin
			case (op_bus.op)
				fp_ctrl_pkg::OP_MUL: res_q <= fp_ctrl_pkg::apb_data_t'(prod);
				fp_ctrl_pkg::OP_I2F: res_q <= fp_ctrl_pkg::apb_data_t'(i2f_word);
				fp_ctrl_pkg::OP_F2I: res_q <= {{16{f2i_int[15]}}, f2i_int};
				fp_ctrl_pkg::OP_CMP: res_q <= fp_ctrl_pkg::apb_data_t'(a_ge_b);
				default: res_q <= '0;
			endcase
		end
	end

	// Adder output is already registered in its second stage
	assign op_bus.result = (op_q == fp_ctrl_pkg::OP_ADD) ? fp_ctrl_pkg::apb_data_t'(sum) : res_q;
	assign op_bus.done = done_q;

endmodule

//--- source/fp_convert.sv
module fp_convert (
	input fp_format_pkg::fp_word_t a,
	input fp_format_pkg::int16_t int_in,
	output fp_format_pkg::fp_word_t fp_out,
	output fp_format_pkg::int16_t int_out
);

	// Integer to float
	logic in_neg;
	logic [15:0] mag;
	logic [3:0] msb_pos;
	logic [33:0] i2f_buf;
	fp_format_pkg::fp_exp_t i2f_exp;

	// Float to integer
	logic a_sign;
	fp_format_pkg::fp_exp_t a_exp;
	logic [33:0] f2i_buf;
	fp_format_pkg::int16_t f2i_mag;

	// ========================================
	// Integer to float
	// ========================================

	assign in_neg = int_in[15];
	// -32768 still fits as unsigned magnitude
	assign mag = in_neg ? 16'(-int_in) : 16'(int_in);

	always_comb begin
		msb_pos = 4'd0;
		for (int i = 0; i < 16; i++) begin
			if (mag[i])
				msb_pos = 4'(i);
		end
	end

	// Leading one moved to bit 18, fraction below it
	assign i2f_buf = {18'b0, mag} << (5'd18 - {1'b0, msb_pos});
	assign i2f_exp = fp_format_pkg::FP_BIAS + {4'b0, msb_pos};

	assign fp_out = (mag == '0) ? fp_format_pkg::FP_ZERO
		: {in_neg, i2f_exp, i2f_buf[fp_format_pkg::FP_FRAC_W-1:0]};

	// ========================================
	// Float to integer
	// ========================================

	assign a_sign = a[fp_format_pkg::FP_SIGN_POS];
	assign a_exp = a[fp_format_pkg::FP_EXP_MSB:fp_format_pkg::FP_EXP_LSB];

	// 1.f with its point at bit 18, scaled by 2^(e-127)
	assign f2i_buf = {15'b0, 1'b1, a[fp_format_pkg::FP_FRAC_W-1:0]}
		<< (a_exp - fp_format_pkg::FP_BIAS);
	assign f2i_mag = fp_format_pkg::int16_t'(f2i_buf[33:18]);

	always_comb begin
		if (a_exp < fp_format_pkg::FP_BIAS)
			int_out = '0;
		else if (a_exp > fp_format_pkg::FP_INT_TOP_EXP)
			int_out = a_sign ? -fp_format_pkg::FP_INT_MAX : fp_format_pkg::FP_INT_MAX;
		else
			int_out = a_sign ? -f2i_mag : f2i_mag;
	end

endmodule

//--- source/fp_mul.sv
module fp_mul (
	input fp_format_pkg::fp_word_t a,
	input fp_format_pkg::fp_word_t b,
	output fp_format_pkg::fp_word_t prod
);

	localparam int MW = fp_format_pkg::FP_MANT_W;

	fp_format_pkg::fp_exp_t a_exp;
	fp_format_pkg::fp_exp_t b_exp;
	logic [2*MW-1:0] mant_prod;
	logic top;
	logic [8:0] exp_sum;
	logic [8:0] exp_out;
	logic underflow;
	fp_format_pkg::fp_frac_t frac_out;

	assign a_exp = a[fp_format_pkg::FP_EXP_MSB:fp_format_pkg::FP_EXP_LSB];
	assign b_exp = b[fp_format_pkg::FP_EXP_MSB:fp_format_pkg::FP_EXP_LSB];

	// 1.f times 1.f lands in [1, 4)
	assign mant_prod = {1'b1, a[fp_format_pkg::FP_FRAC_W-1:0]}
		* {1'b1, b[fp_format_pkg::FP_FRAC_W-1:0]};
	assign top = mant_prod[2*MW-1];

	// Bias counted twice in the sum
	assign exp_sum = {1'b0, a_exp} + {1'b0, b_exp} + {8'b0, top};
	assign underflow = exp_sum <= {1'b0, fp_format_pkg::FP_BIAS};
	assign exp_out = exp_sum - {1'b0, fp_format_pkg::FP_BIAS};

	// Drop the leading one after normalizing
	assign frac_out = top ? mant_prod[2*MW-2 -: fp_format_pkg::FP_FRAC_W]
		: mant_prod[2*MW-3 -: fp_format_pkg::FP_FRAC_W];

	assign prod = (underflow || (a_exp == '0) || (b_exp == '0)) ? fp_format_pkg::FP_ZERO
		: {a[fp_format_pkg::FP_SIGN_POS] ^ b[fp_format_pkg::FP_SIGN_POS], exp_out[7:0], frac_out};

endmodule

//--- source/fp_add.sv
module fp_add (
	input logic iCLK,
	input fp_format_pkg::fp_word_t a,
	input fp_format_pkg::fp_word_t b,
	output fp_format_pkg::fp_word_t sum
);

	// Carry bit, mantissa, 18 guard bits below
	localparam int ACC_W = 2 * fp_format_pkg::FP_MANT_W;
	typedef logic [ACC_W-1:0] acc_t;

	// Input fields
	logic a_sign;
	logic b_sign;
	fp_format_pkg::fp_exp_t a_exp;
	fp_format_pkg::fp_exp_t b_exp;
	logic [fp_format_pkg::FP_MANT_W-1:0] a_mant;
	logic [fp_format_pkg::FP_MANT_W-1:0] b_mant;

	// Stage one
	logic a_larger;
	fp_format_pkg::fp_exp_t exp_diff;
	fp_format_pkg::fp_exp_t larger_exp;
	acc_t a_al;
	acc_t b_al;
	acc_t pre_sum;

	// Stage one registers
	acc_t pre_sum_q;
	fp_format_pkg::fp_exp_t larger_exp_q;
	logic a_zero_q;
	logic b_zero_q;
	fp_format_pkg::fp_word_t a_q;
	fp_format_pkg::fp_word_t b_q;
	logic sign_q;

	// Stage two
	logic [5:0] lz;
	logic [8:0] exp_wide;
	logic underflow;
	acc_t norm;

	// ========================================
	// Stage one: align and add
	// ========================================

	assign a_sign = a[fp_format_pkg::FP_SIGN_POS];
	assign b_sign = b[fp_format_pkg::FP_SIGN_POS];
	assign a_exp = a[fp_format_pkg::FP_EXP_MSB:fp_format_pkg::FP_EXP_LSB];
	assign b_exp = b[fp_format_pkg::FP_EXP_MSB:fp_format_pkg::FP_EXP_LSB];
	// Hidden one restored
	assign a_mant = {1'b1, a[fp_format_pkg::FP_FRAC_W-1:0]};
	assign b_mant = {1'b1, b[fp_format_pkg::FP_FRAC_W-1:0]};

	assign a_larger = (a_exp > b_exp)
		|| ((a_exp == b_exp) && (a_mant > b_mant));
	assign larger_exp = a_larger ? a_exp : b_exp;
	assign exp_diff = a_larger ? (a_exp - b_exp) : (b_exp - a_exp);

	// Smaller operand slides right, gone past the accumulator
	always_comb begin
		a_al = {1'b0, a_mant, {(ACC_W-fp_format_pkg::FP_MANT_W-1){1'b0}}};
		b_al = {1'b0, b_mant, {(ACC_W-fp_format_pkg::FP_MANT_W-1){1'b0}}};
		if (a_larger)
			b_al = (exp_diff >= 8'(ACC_W)) ? '0 : (b_al >> exp_diff);
		else
			a_al = (exp_diff >= 8'(ACC_W)) ? '0 : (a_al >> exp_diff);
	end

	// Unlike signs subtract smaller from larger
	always_comb begin
		if (a_sign == b_sign)
			pre_sum = a_al + b_al;
		else if (a_larger)
			pre_sum = a_al - b_al;
		else
			pre_sum = b_al - a_al;
	end

	always_ff @(posedge iCLK) begin
		pre_sum_q <= pre_sum;
		larger_exp_q <= larger_exp;
		a_zero_q <= (a_exp == '0);
		b_zero_q <= (b_exp == '0);
		a_q <= a;
		b_q <= b;
		sign_q <= a_larger ? a_sign : b_sign;
	end

	// ========================================
	// Stage two: normalize
	// ========================================

	// Leading zeros, highest set bit wins
	always_comb begin
		lz = 6'(ACC_W);
		for (int i = 0; i < ACC_W; i++) begin
			if (pre_sum_q[i])
				lz = 6'(ACC_W - 1 - i);
		end
	end

	// Hidden one sits one below the carry bit
	assign exp_wide = {1'b0, larger_exp_q} + 9'd1 - {3'b0, lz};
	assign underflow = ({1'b0, larger_exp_q} + 9'd1) <= {3'b0, lz};
	assign norm = pre_sum_q << lz;

	always_ff @(posedge iCLK) begin
		if (a_zero_q && b_zero_q)
			sum <= fp_format_pkg::FP_ZERO;
		else if (a_zero_q)
			sum <= b_q;
		else if (b_zero_q)
			sum <= a_q;
		else if (underflow || (pre_sum_q == '0))
			sum <= fp_format_pkg::FP_ZERO;
		else
			sum <= {sign_q, exp_wide[7:0], norm[ACC_W-2 -: fp_format_pkg::FP_FRAC_W]};
	end

endmodule

//--- source/fp_op_if.sv
interface fp_op_if;

	// Operands and op code, held by the register block
	fp_format_pkg::fp_word_t a;
	fp_format_pkg::fp_word_t b;
	fp_ctrl_pkg::fp_op_e op;

	// One-cycle handshake pulses
	logic start;
	logic done;

	// Result in its register form
	fp_ctrl_pkg::apb_data_t result;

	modport regs (output a, b, op, start, input result, done);

	modport exec (input a, b, op, start, output result, done);

endinterface

//--- source/fp_ctrl_pkg.sv
package fp_ctrl_pkg;

	// ========================================
	// Operation codes
	// ========================================

	// Codes 5 to 7 are rejected by the register block
	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_MUL = 3'd1,
		OP_I2F = 3'd2,
		OP_F2I = 3'd3,
		OP_CMP = 3'd4
	} fp_op_e;

	// ========================================
	// APB side
	// ========================================

	localparam int APB_DATA_W = 32;
	typedef logic [APB_DATA_W-1:0] apb_data_t;

	// Register map, byte offsets
	localparam logic [7:0] REG_A = 8'h00;
	localparam logic [7:0] REG_B = 8'h04;
	localparam logic [7:0] REG_CMD = 8'h08;
	localparam logic [7:0] REG_STATUS = 8'h0C;
	localparam logic [7:0] REG_RESULT = 8'h10;

endpackage

//--- source/fp_format_pkg.sv
package fp_format_pkg;

	// ========================================
	// 27-bit float layout
	// ========================================

	// Sign, 8-bit biased exponent, 18-bit fraction
	typedef logic [26:0] fp_word_t;
	typedef logic [7:0] fp_exp_t;
	typedef logic [17:0] fp_frac_t;

	// Integer side of the converters
	typedef logic signed [15:0] int16_t;

	// Field positions inside fp_word_t
	localparam int FP_SIGN_POS = 26;
	localparam int FP_EXP_MSB = 25;
	localparam int FP_EXP_LSB = 18;

	// Stored fraction width, hidden one not counted
	localparam int FP_FRAC_W = 18;

	// Mantissa with the hidden one in front
	localparam int FP_MANT_W = FP_FRAC_W + 1;

	// Exponent of 1.0
	localparam fp_exp_t FP_BIAS = 8'd127;

	// Zero exponent field means the value is zero
	localparam fp_word_t FP_ZERO = '0;

	// ========================================
	// Float to integer limits
	// ========================================

	// Saturation magnitude
	localparam int16_t FP_INT_MAX = 16'sd32767;

	// 2^14 still fits, anything above saturates
	localparam fp_exp_t FP_INT_TOP_EXP = 8'd141;

endpackage
